/* bench/trig_meter_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the top level handshakes and the
// serial line, bound to the meter top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module trig_meter_asserts import trig_meter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic tx,
	input logic report_valid,
	input logic report_ready,
	input pulse_report_t report,
	input logic byte_valid,
	input logic byte_ready,
	input logic [7:0] byte_data
);

	// line idles high from the first reset edge on
	tx_idle_in_reset: assert property (@(posedge clock) reset |=> tx)
		else $error("serial line not idle during reset");

	// a waiting report stays offered and is held or replaced by the next pulse
	report_held: assert property (@(posedge clock) disable iff (reset)
		report_valid && !report_ready |=> report_valid &&
		($stable(report) || report.pulse_number == $past(report.pulse_number) + 1'b1))
		else $error("pending report dropped or changed without a newer pulse");

	byte_held: assert property (@(posedge clock) disable iff (reset)
		byte_valid && !byte_ready |=> byte_valid && $stable(byte_data))
		else $error("offered byte changed before the transmitter took it");

	no_byte_in_reset: assert property (@(posedge clock) reset |-> !$rose(byte_valid))
		else $error("byte offered during reset");

endmodule

bind trig_meter_top trig_meter_asserts i_asserts (.*);

/* bench/trig_meter_input.txt */
// columns, hex: high cycles of the pulse, extra low cycles after it
// every gap also gets 4 low cycles and a random 0 to 63 more
0005 0300
0001 0300
0040 0300
3039 0300
11170 0300
00ff 0300
0010 0000
0020 0000
0008 0080
0030 0040
0007 0300
1000 0020
0002 0300
0003 0000
0009 0300

/* bench/trig_meter_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// file-driven trigger pulses, serial line decoder, report
// line and running total checks, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module trig_meter_tb import trig_meter_pkg::*; ();

	localparam int clks_per_bit = 4;
	localparam int max_pulses = 64;
	localparam int min_gap = 4;
	// a pulse ending this long before a line starts was taken by it
	localparam int take_window = 48;

	logic clock;
	logic reset;
	logic trigger;
	logic tx;
	logic tx_busy;
	logic [total_width-1:0] total_high_cycles;

	logic [31:0] stim_mem [0:2*max_pulses-1];
	logic [7:0] line_chars [0:line_length-1];
	int exp_duration [1:max_pulses];
	longint fall_cycle [1:max_pulses];
	int pulse_total = 0;
	int pulses_done = 0;
	int last_reported = 0;
	int line_count = 0;
	longint cycle = 0;
	longint last_line_end = 0;
	longint exp_total = 0;
	longint watchdog_cycles = 0;
	int unsigned lcg_state = 88;

	trig_meter_top #(.clks_per_bit(clks_per_bit)) i_dut (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.tx(tx),
		.tx_busy(tx_busy),
		.total_high_cycles(total_high_cycles)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	always @(posedge clock)
		cycle <= cycle + 1;

	function automatic int unsigned lcg_next(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// character at a line position with digits most significant first
	function automatic logic [7:0] expected_char(input int number, input int duration,
		input int pos);
		int value;
		int places;
		if (pos == bcd_digits)
			return char_space;
		if (pos == line_length - 2)
			return char_cr;
		if (pos == line_length - 1)
			return char_lf;
		value = (pos < bcd_digits) ? number : duration;
		places = (pos < bcd_digits) ? bcd_digits - 1 - pos : 2 * bcd_digits - pos;
		for (int i = 0; i < places; i++)
			value = value / 10;
		return char_digit_base + 8'(value % 10);
	endfunction

	function automatic int field_value(input int first);
		int value;
		value = 0;
		for (int i = first; i < first + bcd_digits; i++)
			value = value * 10 + int'(line_chars[i] - char_digit_base);
		return value;
	endfunction

	task automatic abort_run(input string text);
		$display("%s", text);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input longint expected,
		input longint actual);
		abort_run($sformatf("** Error %s: expected %0d, actual %0d", test, expected, actual));
	endtask

	// latest pulse wins so the number lies between the newest pulse that
	// must have been taken and the newest that had ended at all
	task automatic check_line(input longint line_start);
		int number;
		int lowest;
		int highest;
		number = field_value(0);
		lowest = last_reported + 1;
		highest = last_reported;
		for (int p = last_reported + 1; p <= pulses_done; p++) begin
			if (fall_cycle[p] < line_start)
				highest = p;
			if (fall_cycle[p] + take_window < line_start)
				lowest = p;
		end
		assert (number >= lowest && number <= highest)
			else report_mismatch("pulse number", highest, number);
		// a skipped pulse must have ended while the previous line was still going
		for (int q = last_reported + 1; q < number; q++) begin
			assert (fall_cycle[q] < last_line_end)
				else abort_run($sformatf("pulse %0d ended on an idle line and was not reported",
					q));
		end
		for (int i = 0; i < line_length; i++) begin
			assert (line_chars[i] === expected_char(number, exp_duration[number], i))
				else report_mismatch($sformatf("line %0d char %0d", line_count + 1, i),
					expected_char(number, exp_duration[number], i), line_chars[i]);
		end
		last_reported = number;
		last_line_end = cycle;
		line_count++;
	endtask

	initial begin
		int high;
		int gap;
		longint limit;
		reset = 1'b1;
		trigger = 1'b0;
		for (int i = 0; i < 2 * max_pulses; i++)
			stim_mem[i] = '0;
		$readmemh("bench/trig_meter_input.txt", stim_mem);
		limit = 200;
		while (pulse_total < max_pulses && stim_mem[2 * pulse_total] != 0) begin
			limit += stim_mem[2 * pulse_total] + stim_mem[2 * pulse_total + 1];
			limit += min_gap + 64 + 700;
			pulse_total++;
		end
		if (pulse_total == 0)
			abort_run("stimulus file holds no pulses");
		watchdog_cycles = limit;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (20) begin
			@(negedge clock);
			assert (tx === 1'b1) else report_mismatch("idle tx", 1, tx);
			assert (tx_busy === 1'b0) else report_mismatch("idle tx_busy", 0, tx_busy);
			assert (total_high_cycles === '0)
				else report_mismatch("idle total", 0, total_high_cycles);
		end
		for (int p = 1; p <= pulse_total; p++) begin
			high = stim_mem[2 * (p - 1)];
			lcg_state = lcg_next(lcg_state);
			gap = min_gap + stim_mem[2 * (p - 1) + 1] + (lcg_state >> 16) % 64;
			trigger = 1'b1;
			repeat (high) @(negedge clock);
			trigger = 1'b0;
			exp_duration[p] = (high > 65535) ? 65535 : high;
			exp_total += exp_duration[p];
			if (exp_total > 64'hffffffff)
				exp_total = 64'hffffffff;
			fall_cycle[p] = cycle;
			pulses_done = p;
			for (int i = 1; i <= gap; i++) begin
				@(negedge clock);
				if (i == 4)
					assert (total_high_cycles == exp_total)
						else report_mismatch("running total", exp_total, total_high_cycles);
			end
		end
		wait (last_reported == pulse_total);
		repeat (4 * clks_per_bit) @(negedge clock);
		if (line_count > 0 && tx === 1'b1 && tx_busy === 1'b0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run("serial line not idle after the last report line");
		end
	end

	// serial decoder sampling mid-bit on the falling clock edge
	initial begin
		logic [7:0] data;
		int char_pos;
		longint line_start;
		char_pos = 0;
		line_start = 0;
		wait (reset === 1'b0);
		forever begin
			@(negedge clock);
			if (tx === 1'b0) begin
				if (char_pos == 0)
					line_start = cycle;
				repeat (clks_per_bit / 2) @(negedge clock);
				assert (tx === 1'b0) else abort_run("start bit too short on the serial line");
				assert (tx_busy === 1'b1) else report_mismatch("frame tx_busy", 1, tx_busy);
				for (int b = 0; b < 8; b++) begin
					repeat (clks_per_bit) @(negedge clock);
					data[b] = tx;
				end
				repeat (clks_per_bit) @(negedge clock);
				assert (tx === 1'b1) else abort_run("missing stop bit on the serial line");
				line_chars[char_pos] = data;
				char_pos++;
				if (char_pos == line_length) begin
					check_line(line_start);
					char_pos = 0;
				end
			end
		end
	end

	initial begin
		wait (watchdog_cycles > 0);
		#(watchdog_cycles * 40);
		abort_run("timeout: the report lines did not all arrive in time");
	end

endmodule

/* files.f */
rtl/trig_meter_pkg.sv
rtl/pulse_width_meter.sv
rtl/bin_to_bcd.sv
rtl/report_line_formatter.sv
rtl/uart_tx.sv
rtl/trig_meter_top.sv
bench/trig_meter_asserts.sv
bench/trig_meter_tb.sv

/* rtl/bin_to_bcd.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequential double-dabble, 16-bit binary to six bcd digits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bin_to_bcd import trig_meter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic conv_start,
	input logic [value_width-1:0] conv_value,
	output logic conv_done,
	output logic [4*bcd_digits-1:0] conv_bcd
);

	logic [$clog2(value_width+1)-1:0] bits_left;
	logic [value_width-1:0] value_reg;
	logic [4*bcd_digits-1:0] bcd_reg;
	logic [4*bcd_digits-1:0] bcd_adjusted;

	assign conv_bcd = bcd_reg;

	// add 3 to every digit of 5 or more before the shift
	always_comb begin
		bcd_adjusted = bcd_reg;
		for (int i = 0; i < bcd_digits; i++) begin
			if (bcd_reg[4*i +: 4] >= 4'd5)
				bcd_adjusted[4*i +: 4] = bcd_reg[4*i +: 4] + 4'd3;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bits_left <= '0;
			conv_done <= 1'b0;
		end else begin
			conv_done <= 1'b0;
			if (conv_start) begin
				bits_left <= value_width[$bits(bits_left)-1:0];
			end else if (bits_left != '0) begin
				bits_left <= bits_left - 1'b1;
				// last shift, result is in bcd_reg next cycle
				conv_done <= (bits_left == 1);
			end
		end
	end

	// one input bit moves into the bcd word per cycle
	always_ff @(posedge clock) begin
		if (conv_start) begin
			value_reg <= conv_value;
			bcd_reg <= '0;
		end else if (bits_left != '0) begin
			value_reg <= value_reg << 1;
			bcd_reg <= {bcd_adjusted[4*bcd_digits-2:0], value_reg[value_width-1]};
		end
	end

endmodule

/* rtl/pulse_width_meter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger synchronizer, falling edge detection, duration and
// total counters, pending report with latest-wins replacement
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pulse_width_meter import trig_meter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic trigger,
	input logic report_ready,
	output logic report_valid,
	output pulse_report_t report,
	output logic [total_width-1:0] total_high_cycles
);

	// [1:0] is the synchronizer, [2] one more sample for the edge
	logic [2:0] trigger_stream;
	logic falling_edge;
	logic [value_width-1:0] duration_count;
	logic [value_width-1:0] pulse_count;
	logic [total_width:0] total_sum;

	assign falling_edge = (trigger_stream[2:1] == 2'b10);
	assign total_sum = {1'b0, total_high_cycles} + (total_width + 1)'(duration_count);

	always_ff @(posedge clock) begin
		if (reset) begin
			trigger_stream <= '0;
			duration_count <= '0;
			pulse_count <= '0;
			total_high_cycles <= '0;
			report_valid <= 1'b0;
		end else begin
			trigger_stream <= {trigger_stream[1:0], trigger};
			if (trigger_stream[1]) begin
				// hold at the top instead of wrapping
				if (duration_count != '1)
					duration_count <= duration_count + 1'b1;
			end else if (falling_edge) begin
				duration_count <= '0;
				pulse_count <= pulse_count + 1'b1;
				if (total_sum[total_width])
					total_high_cycles <= '1;
				else
					total_high_cycles <= total_sum[total_width-1:0];
			end
			// a new edge overrides the handshake, latest pulse wins
			if (falling_edge)
				report_valid <= 1'b1;
			else if (report_ready)
				report_valid <= 1'b0;
		end
	end

	// pending report, overwritten by a newer pulse
	always_ff @(posedge clock) begin
		if (falling_edge) begin
			report.pulse_number <= pulse_count + 1'b1;
			report.duration <= duration_count;
		end
	end

endmodule

/* rtl/report_line_formatter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// report line formatter: two conversions, then 15 ascii bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module report_line_formatter import trig_meter_pkg::*; (
	input logic clock,
	input logic reset,
	input logic report_valid,
	input pulse_report_t report,
	input logic byte_ready,
	output logic report_ready,
	output logic byte_valid,
	output logic [7:0] byte_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_conv_number,
		st_conv_duration,
		st_send
	} state_t;

	state_t state;
	pulse_report_t report_reg;
	logic conv_start;
	logic [value_width-1:0] conv_value;
	logic conv_done;
	logic [4*bcd_digits-1:0] conv_bcd;
	logic [4*bcd_digits-1:0] number_bcd;
	logic [4*bcd_digits-1:0] duration_bcd;
	logic [$clog2(line_length)-1:0] char_index;
	logic [3:0] digit;

	// one converter shared by both fields
	bin_to_bcd i_bin_to_bcd (
		.clock(clock),
		.reset(reset),
		.conv_start(conv_start),
		.conv_value(conv_value),
		.conv_done(conv_done),
		.conv_bcd(conv_bcd)
	);

	assign conv_value = (state == st_conv_duration) ? report_reg.duration
		: report_reg.pulse_number;
	assign report_ready = (state == st_idle);
	assign byte_valid = (state == st_send);

	// digits most significant first, fields split by a space
	always_comb begin
		digit = '0;
		byte_data = char_space;
		if (char_index < bcd_digits) begin
			digit = number_bcd[(bcd_digits - 1 - char_index) * 4 +: 4];
			byte_data = char_digit_base + {4'b0, digit};
		end else if (char_index > bcd_digits && char_index <= 2 * bcd_digits) begin
			digit = duration_bcd[(2 * bcd_digits - char_index) * 4 +: 4];
			byte_data = char_digit_base + {4'b0, digit};
		end else if (char_index == line_length - 2) begin
			byte_data = char_cr;
		end else if (char_index == line_length - 1) begin
			byte_data = char_lf;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			conv_start <= 1'b0;
			char_index <= '0;
		end else begin
			conv_start <= 1'b0;
			case (state)
				st_idle: if (report_valid) begin
					state <= st_conv_number;
					conv_start <= 1'b1;
				end
				st_conv_number: if (conv_done) begin
					state <= st_conv_duration;
					conv_start <= 1'b1;
				end
				st_conv_duration: if (conv_done) begin
					state <= st_send;
					char_index <= '0;
				end
				st_send: if (byte_ready) begin
					if (char_index == line_length - 1)
						state <= st_idle;
					else
						char_index <= char_index + 1'b1;
				end
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clock) begin
		if (state == st_idle && report_valid)
			report_reg <= report;
		if (state == st_conv_number && conv_done)
			number_bcd <= conv_bcd;
		if (state == st_conv_duration && conv_done)
			duration_bcd <= conv_bcd;
	end

endmodule

/* rtl/trig_meter_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, the pulse report struct and ASCII constants
// for the trigger pulse-width meter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package trig_meter_pkg;

	// pulse number and duration width
	localparam int value_width = 16;

	// accumulated high-cycle total
	localparam int total_width = 32;

	// decimal digits per printed field, 4 bits each
	localparam int bcd_digits = 6;

	// six digits, space, six digits, cr, lf
	localparam int line_length = 15;

	// one finished pulse, meter to formatter
	typedef struct packed {
		logic [value_width-1:0] pulse_number;
		// saturates at all ones
		logic [value_width-1:0] duration;
	} pulse_report_t;

	// ascii characters of a report line
	localparam logic [7:0] char_space = 8'h20;
	localparam logic [7:0] char_cr = 8'h0d;
	localparam logic [7:0] char_lf = 8'h0a;

	// '0', a bcd digit is added to it
	localparam logic [7:0] char_digit_base = 8'h30;

endpackage

/* rtl/trig_meter_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger pulse-width meter top: meter, formatter, uart
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module trig_meter_top import trig_meter_pkg::*; #(
	parameter int clks_per_bit = 868
) (
	input logic clock,
	input logic reset,
	input logic trigger,
	output logic tx,
	output logic tx_busy,
	output logic [total_width-1:0] total_high_cycles
);

	logic report_valid;
	logic report_ready;
	pulse_report_t report;
	logic byte_valid;
	logic byte_ready;
	logic [7:0] byte_data;

	pulse_width_meter i_meter (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.report_ready(report_ready),
		.report_valid(report_valid),
		.report(report),
		.total_high_cycles(total_high_cycles)
	);

	report_line_formatter i_formatter (
		.clock(clock),
		.reset(reset),
		.report_valid(report_valid),
		.report(report),
		.byte_ready(byte_ready),
		.report_ready(report_ready),
		.byte_valid(byte_valid),
		.byte_data(byte_data)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) i_uart_tx (
		.clock(clock),
		.reset(reset),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.byte_ready(byte_ready),
		.tx(tx),
		.tx_busy(tx_busy)
	);

endmodule

/* rtl/uart_tx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 uart transmitter with a valid/ready byte input
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_tx #(
	parameter int clks_per_bit = 868
) (
	input logic clock,
	input logic reset,
	input logic byte_valid,
	input logic [7:0] byte_data,
	output logic byte_ready,
	output logic tx,
	output logic tx_busy
);

	localparam int count_width = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

	logic [count_width-1:0] period_count;
	logic [3:0] bit_index;
	// stop, data lsb first, start
	logic [9:0] frame;

	assign byte_ready = !tx_busy;
	assign tx = tx_busy ? frame[0] : 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			tx_busy <= 1'b0;
			period_count <= '0;
			bit_index <= '0;
		end else if (!tx_busy) begin
			if (byte_valid) begin
				tx_busy <= 1'b1;
				period_count <= '0;
				bit_index <= '0;
			end
		end else if (period_count == count_width'(clks_per_bit - 1)) begin
			period_count <= '0;
			// stop bit done
			if (bit_index == 4'd9)
				tx_busy <= 1'b0;
			else
				bit_index <= bit_index + 1'b1;
		end else begin
			period_count <= period_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!tx_busy && byte_valid)
			frame <= {1'b1, byte_data, 1'b0};
		else if (tx_busy && period_count == count_width'(clks_per_bit - 1))
			frame <= {1'b1, frame[9:1]};
	end

endmodule
